//--- Bender.yml
package:
  name: sliding_detector

sources:
  - include_dirs:
      - src
    files:
      - src/detector_pkg.sv
      - src/history_if.sv
      - src/word_history.sv
      - src/sliding_detector.sv
      - src/error_corrector.sv
      - src/credit_counter.sv
      - src/detector_ctrl.sv
      - src/sliding_detector_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - verification/tb_sliding_detector.sv

//--- src/credit_counter.sv
`timescale 1ns/100ps
`include "detector_params.svh"

module credit_counter (
    input  logic clk,
    input  logic reset,
    input  logic credit_return,
    input  logic take_credit,
    output logic credit_avail
);

    localparam int CNT_BITS = $clog2(`DET_CREDITS + 1);

    logic [CNT_BITS-1:0] count;

    // A return and a take in the same cycle cancel out
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= CNT_BITS'(`DET_CREDITS);
        end else if (credit_return && !take_credit) begin
            count <= count + 1'b1;
        end else if (take_credit && !credit_return) begin
            count <= count - 1'b1;
        end
    end

    assign credit_avail = count != '0;

    // Downstream never returns more than it was given
    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        count <= CNT_BITS'(`DET_CREDITS));

    a_no_underflow: assert property (@(posedge clk) disable iff (reset)
        take_credit |-> count != '0);

endmodule : credit_counter

//--- src/detector_ctrl.sv
`timescale 1ns/100ps
`include "detector_params.svh"

module detector_ctrl
    import detector_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  in_valid,
    input  logic                  in_last,
    input  logic [`DET_WIDTH-1:0] in_bits,
    input  err_t                  in_errs [`DET_WIDTH],
    input  logic                  credit_avail,
    output logic                  in_ready,
    output logic                  take_credit,
    output logic                  decide,
    history_if.ctrl               hist
);

    ctrl_state_e state;
    logic        flush_done;   // Zero word is in, clear follows
    logic        flushing;
    logic        push;

    assign flushing = state == st_flush;

    // The first word of a burst has nothing to decide yet, so it needs no credit
    always_comb begin
        case (state)
            st_empty: in_ready = 1'b1;
            st_run:   in_ready = credit_avail;
            default:  in_ready = 1'b0;
        endcase
    end

    assign push        = flushing ? (credit_avail && !flush_done) : (in_valid && in_ready);
    assign take_credit = push && (state != st_empty);

    assign hist.push      = push;
    assign hist.clear     = flushing && flush_done;
    assign hist.push_bits = flushing ? '0 : in_bits;

    always_comb begin
        for (int b = 0; b < `DET_WIDTH; b++) begin
            hist.push_errs[b] = flushing ? err_t'(0) : in_errs[b];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= st_empty;
            flush_done <= 1'b0;
            decide     <= 1'b0;
        end else begin
            decide <= take_credit;   // Middle word is valid the cycle after the shift
            case (state)
                st_empty: begin
                    if (push) begin
                        state <= in_last ? st_flush : st_run;
                    end
                end
                st_run: begin
                    if (push && in_last) begin
                        state <= st_flush;
                    end
                end
                st_flush: begin
                    if (flush_done) begin
                        state      <= st_empty;
                        flush_done <= 1'b0;
                    end else if (push) begin
                        flush_done <= 1'b1;
                    end
                end
                default: state <= st_empty;
            endcase
        end
    end

    // The sender holds a refused word until it is taken
    a_input_held: assert property (@(posedge clk) disable iff (reset)
        (in_valid && !in_ready) |=> (in_valid && $stable(in_bits) && $stable(in_last)));

endmodule : detector_ctrl

//--- src/detector_params.svh
`ifndef DETECTOR_PARAMS_SVH
`define DETECTOR_PARAMS_SVH

// Bits per slicer word
`define DET_WIDTH 16

// Samples summed per hypothesis, must stay below DET_WIDTH
`define DET_SEQ_LENGTH 3
`define DET_TAPS (`DET_SEQ_LENGTH + 1)

`define DET_ERR_BITS 8
`define DET_TAP_BITS 8

`define DET_HIST_WORDS 3
`define DET_CREDITS 4   // Downstream buffer slots

`endif

//--- src/detector_pkg.sv
`include "detector_params.svh"

package detector_pkg;

    // An error plus two taps needs two extra bits over the wider operand
    localparam int RES_BITS = ((`DET_ERR_BITS > `DET_TAP_BITS) ?
                               `DET_ERR_BITS : `DET_TAP_BITS) + 2;
    localparam int SQR_BITS = 2 * RES_BITS;
    localparam int SUM_BITS = SQR_BITS + $clog2(`DET_SEQ_LENGTH);

    typedef logic signed [`DET_ERR_BITS-1:0] err_t;
    typedef logic signed [`DET_TAP_BITS-1:0] tap_t;
    typedef logic signed [RES_BITS-1:0]      res_t;
    typedef logic        [SQR_BITS-1:0]      sqr_t;
    typedef logic        [SUM_BITS-1:0]      sum_t;

    typedef enum logic [1:0] {
        cand_none = 2'd0,
        cand_prev = 2'd1,
        cand_this = 2'd2,
        cand_both = 2'd3
    } cand_e;

    typedef enum logic [1:0] {
        st_empty,
        st_run,
        st_flush
    } ctrl_state_e;

endpackage : detector_pkg

//--- src/error_corrector.sv
`timescale 1ns/100ps
`include "detector_params.svh"

module error_corrector
    import detector_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  decide,
    input  logic                  mid_bits [`DET_WIDTH],
    input  cand_e                 best [`DET_WIDTH],
    output logic                  out_valid,
    output logic [`DET_WIDTH-1:0] out_bits
);

    logic [`DET_WIDTH-1:0] flip;

    // A bit is flipped by its own hypothesis or by the next bit's previous-bit hypothesis
    always_comb begin
        for (int k = 0; k < `DET_WIDTH; k++) begin
            flip[k] = (best[k] == cand_this) || (best[k] == cand_both);
            if (k + 1 < `DET_WIDTH) begin
                flip[k] = flip[k] || (best[k+1] == cand_prev) || (best[k+1] == cand_both);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (decide) begin
            for (int k = 0; k < `DET_WIDTH; k++) begin
                out_bits[k] <= mid_bits[k] ^ flip[k];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= decide;   // One cycle per decided word
        end
    end

    // A decided word never leaves with unknown bits
    a_bits_known: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> !$isunknown(out_bits));

endmodule : error_corrector

//--- src/history_if.sv
`timescale 1ns/100ps
`include "detector_params.svh"

interface history_if import detector_pkg::*; ();

    logic                  push;
    logic                  clear;
    logic [`DET_WIDTH-1:0] push_bits;
    err_t                  push_errs [`DET_WIDTH];

    modport ctrl (
        output push,
        output clear,
        output push_bits,
        output push_errs
    );

    // History side, shared by the bit and the error buffers
    modport buffer (
        input push,
        input clear,
        input push_bits,
        input push_errs
    );

endinterface : history_if

//--- src/sliding_detector.sv
`timescale 1ns/100ps
`include "detector_params.svh"

module sliding_detector
    import detector_pkg::*;
(
    input  err_t  errs [`DET_HIST_WORDS*`DET_WIDTH],
    input  logic  bits [`DET_HIST_WORDS*`DET_WIDTH],
    input  tap_t  taps [`DET_TAPS],
    output cand_e best [`DET_WIDTH]
);

    localparam int MID = `DET_WIDTH;   // First entry of the word being decided

    sum_t sums [4][`DET_WIDTH];

    // Inverse error vector entry, its sign follows the decided bit
    function automatic res_t inv_err(input logic bit_val, input tap_t tap);
        return bit_val ? res_t'(tap) : -res_t'(tap);
    endfunction

    function automatic sqr_t square(input res_t v);
        logic signed [SQR_BITS-1:0] wide;
        wide = v;
        return sqr_t'(wide * wide);
    endfunction

    always_comb begin
        res_t r;
        res_t e_prev;
        res_t e_this;
        for (int i = 0; i < `DET_WIDTH; i++) begin
            for (int c = 0; c < 4; c++) begin
                sums[c][i] = '0;
            end
            for (int s = 0; s < `DET_SEQ_LENGTH; s++) begin
                r      = res_t'(errs[MID+i+s]);
                e_prev = inv_err(bits[MID+i-1], taps[s+1]);  // Previous bit is one tap ahead
                e_this = inv_err(bits[MID+i], taps[s]);
                sums[cand_none][i] = sums[cand_none][i] + square(r);
                sums[cand_prev][i] = sums[cand_prev][i] + square(r + e_prev);
                sums[cand_this][i] = sums[cand_this][i] + square(r + e_this);
                sums[cand_both][i] = sums[cand_both][i] + square(r + e_prev + e_this);
            end
        end
    end

    // Strict compare keeps the lower candidate on a tie
    always_comb begin
        sum_t low;
        for (int i = 0; i < `DET_WIDTH; i++) begin
            low     = sums[cand_none][i];
            best[i] = cand_none;
            for (int c = 1; c < 4; c++) begin
                if (sums[c][i] < low) begin
                    low     = sums[c][i];
                    best[i] = cand_e'(c);
                end
            end
        end
    end

endmodule : sliding_detector

//--- src/sliding_detector_top.sv
`timescale 1ns/100ps
`include "detector_params.svh"

module sliding_detector_top
    import detector_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  logic                  in_last,
    input  logic [`DET_WIDTH-1:0] in_bits,
    input  err_t                  in_errs [`DET_WIDTH],
    input  tap_t                  taps [`DET_TAPS],
    output logic                  out_valid,
    output logic [`DET_WIDTH-1:0] out_bits,
    input  logic                  credit_return
);

    logic  credit_avail;
    logic  take_credit;
    logic  decide;
    logic  bit_win [`DET_HIST_WORDS*`DET_WIDTH];
    err_t  err_win [`DET_HIST_WORDS*`DET_WIDTH];
    cand_e best [`DET_WIDTH];

    history_if hist ();

    detector_ctrl u_ctrl (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_last      (in_last),
        .in_bits      (in_bits),
        .in_errs      (in_errs),
        .credit_avail (credit_avail),
        .in_ready     (in_ready),
        .take_credit  (take_credit),
        .decide       (decide),
        .hist         (hist.ctrl)
    );

    credit_counter u_credits (
        .clk           (clk),
        .reset         (reset),
        .credit_return (credit_return),
        .take_credit   (take_credit),
        .credit_avail  (credit_avail)
    );

    word_history #(.sample_t(logic), .select_errs(1'b0)) u_bit_hist (
        .clk    (clk),
        .reset  (reset),
        .hist   (hist.buffer),
        .window (bit_win)
    );

    word_history #(.sample_t(err_t), .select_errs(1'b1)) u_err_hist (
        .clk    (clk),
        .reset  (reset),
        .hist   (hist.buffer),
        .window (err_win)
    );

    sliding_detector u_detector (
        .errs (err_win),
        .bits (bit_win),
        .taps (taps),
        .best (best)
    );

    // Only the middle word of the bit window is corrected
    error_corrector u_corrector (
        .clk       (clk),
        .reset     (reset),
        .decide    (decide),
        .mid_bits  (bit_win[`DET_WIDTH:2*`DET_WIDTH-1]),
        .best      (best),
        .out_valid (out_valid),
        .out_bits  (out_bits)
    );

endmodule : sliding_detector_top

//--- src/word_history.sv
`timescale 1ns/100ps
`include "detector_params.svh"

module word_history
    import detector_pkg::*;
#(
    parameter type sample_t    = logic,
    parameter bit  select_errs = 1'b0
) (
    input  logic       clk,
    input  logic       reset,
    history_if.buffer  hist,
    output sample_t    window [`DET_HIST_WORDS*`DET_WIDTH]
);

    localparam int N_ENTRIES = `DET_HIST_WORDS * `DET_WIDTH;
    localparam int NEWEST    = N_ENTRIES - `DET_WIDTH;

    sample_t new_word [`DET_WIDTH];

    if (select_errs) begin : g_errs
        always_comb begin
            for (int b = 0; b < `DET_WIDTH; b++) begin
                new_word[b] = sample_t'(hist.push_errs[b]);
            end
        end
    end else begin : g_bits
        always_comb begin
            for (int b = 0; b < `DET_WIDTH; b++) begin
                new_word[b] = sample_t'(hist.push_bits[b]);
            end
        end
    end

    // Word 0 is the oldest, the newest word enters at the top
    always_ff @(posedge clk) begin
        if (reset || hist.clear) begin
            for (int k = 0; k < N_ENTRIES; k++) begin
                window[k] <= '0;
            end
        end else if (hist.push) begin
            for (int k = 0; k < NEWEST; k++) begin
                window[k] <= window[k+`DET_WIDTH];
            end
            for (int b = 0; b < `DET_WIDTH; b++) begin
                window[NEWEST+b] <= new_word[b];
            end
        end
    end

endmodule : word_history

//--- verification/tb_sliding_detector.sv
`timescale 1ns/100ps
`include "detector_params.svh"

module tb_sliding_detector
    import detector_pkg::*;
();

    localparam int W  = `DET_WIDTH;
    localparam int EB = `DET_ERR_BITS;
    localparam int TB = `DET_TAP_BITS;

    logic clk;
    logic reset;
    logic in_valid;
    logic in_ready;
    logic in_last;
    logic out_valid;
    logic credit_return;
    logic [W-1:0] in_bits;
    logic [W-1:0] out_bits;
    err_t in_errs [W];
    tap_t taps [`DET_TAPS];

    integer seed = 32'h64807112;
    int tap_int [`DET_TAPS];
    logic [`DET_TAPS*TB-1:0] tap_vec;
    logic [3*W-1:0] model_bits;      // Word 0 is the oldest
    logic [3*W*EB-1:0] model_errs;
    logic [W-1:0] exp_q [$];
    int due_q [$];                   // Cycle at which each credit goes back
    int cycle;
    int out_count;
    int in_flight;
    int cand_hits [4];
    bit hold_credits;

    sliding_detector_top UUT (.*);

    always #2 clk = ~clk;

    always @(posedge clk) cycle++;

    function automatic logic [W-1:0] ref_correct(input logic [3*W-1:0] bits,
                                                 input logic [3*W*EB-1:0] errs,
                                                 input logic [`DET_TAPS*TB-1:0] tv);
        int sum [4];
        int r;
        int ep;
        int et;
        int win;
        logic [W-1:0] flip;
        flip = '0;
        for (int i = 0; i < W; i++) begin
            sum = '{default: 0};
            for (int s = 0; s < `DET_SEQ_LENGTH; s++) begin
                r  = $signed(errs[(W+i+s)*EB +: EB]);
                ep = $signed(tv[(s+1)*TB +: TB]);
                et = $signed(tv[s*TB +: TB]);
                if (!bits[W+i-1]) ep = -ep;
                if (!bits[W+i]) et = -et;
                sum[0] += r * r;
                sum[1] += (r + ep) * (r + ep);
                sum[2] += (r + et) * (r + et);
                sum[3] += (r + ep + et) * (r + ep + et);
            end
            win = 0;
            for (int c = 1; c < 4; c++) begin
                if (sum[c] < sum[win]) win = c;
            end
            cand_hits[win]++;
            if (win >= 2) flip[i] = 1'b1;
            if (i > 0 && win % 2 == 1) flip[i-1] = 1'b1;   // Bits of the previous word stay sent
        end
        return bits[2*W-1:W] ^ flip;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("Mismatch at %0t ns: %s expected %h, actual %h",
                                $time, name, expected, actual));
        end
    endtask

    task automatic build_word(input bit inject, output logic [W-1:0] bits,
                              output logic [W*EB-1:0] errs);
        int e [W];
        int flips [$];
        int p;
        int inv;
        bits = $random(seed);
        p = 1 + $unsigned($random(seed)) % (W - 3);
        for (int b = 0; b < W; b++) e[b] = inject ? $random(seed) % 4 : 0;
        if (inject) begin
            case ($unsigned($random(seed)) % 4)
                1: flips = '{p};
                2: flips = '{p - 1, p};
                3: flips = '{p, p + 2};
                default: ;
            endcase
        end
        // A wrong decision leaves the negated inverse error on the following samples
        foreach (flips[f]) begin
            for (int t = 0; t < `DET_TAPS; t++) begin
                inv = bits[flips[f]] ? tap_int[t] : -tap_int[t];
                if (flips[f] + t < W) e[flips[f] + t] -= inv;
            end
        end
        for (int b = 0; b < W; b++) errs[b*EB +: EB] = e[b][EB-1:0];
    endtask

    // Step n of the model stands for the zero flush word
    task automatic send_burst(input int n, input bit inject);
        logic [W-1:0] bits;
        logic [W*EB-1:0] errs;
        int waited;
        @(posedge clk);
        #0.5;
        for (int k = 0; k <= n; k++) begin
            bits = '0;
            errs = '0;
            if (k < n) begin
                build_word(inject, bits, errs);
                in_valid = 1'b1;
                in_last  = k == n - 1;
                in_bits  = bits;
                for (int b = 0; b < W; b++) in_errs[b] = err_t'(errs[b*EB +: EB]);
                waited = 0;
                do begin
                    @(negedge clk);
                    waited++;
                    if (waited > 200) abort_run("Timed out waiting for in_ready");
                end while (!in_ready);
                @(posedge clk);
                #0.5;
            end
            model_bits = {bits, model_bits[3*W-1:W]};
            model_errs = {errs, model_errs[3*W*EB-1:W*EB]};
            if (k > 0) begin
                if (inject) begin
                    exp_q.push_back(ref_correct(model_bits, model_errs, tap_vec));
                end else begin
                    exp_q.push_back(model_bits[2*W-1:W]);   // Zero errors leave the word as sent
                end
            end
        end
        in_valid   = 1'b0;
        in_last    = 1'b0;
        model_bits = '0;
        model_errs = '0;
    endtask

    task automatic wait_outputs(input int target);
        int waited;
        waited = 0;
        while (out_count < target || (!hold_credits && due_q.size() != 0)) begin
            @(negedge clk);
            waited++;
            if (waited > 400) abort_run("Timed out waiting for outputs and returned credits");
        end
    endtask

    task automatic run_burst(input int n, input bit inject);
        int first;
        first = out_count;
        send_burst(n, inject);
        wait_outputs(first + n);
        check_value("output count", n, out_count - first);
    endtask

    always @(posedge clk) begin
        #0.5;
        credit_return = 1'b0;
        if (!hold_credits && due_q.size() != 0 && due_q[0] <= cycle) begin
            credit_return = 1'b1;
            void'(due_q.pop_front());
            in_flight--;
        end
    end

    always @(negedge clk) begin
        if (!reset && out_valid) begin
            if (exp_q.size() == 0) begin
                abort_run("out_valid was high with no word expected");
            end else begin
                check_value("out_bits", exp_q.pop_front(), out_bits);
                out_count++;
                in_flight++;
                due_q.push_back(cycle + $unsigned($random(seed)) % 6);
                if (in_flight > `DET_CREDITS) abort_run("More outputs in flight than credits");
            end
        end
    end

    initial begin
        int first;
        clk           = 1'b0;
        reset         = 1'b1;
        in_valid      = 1'b0;
        in_last       = 1'b0;
        in_bits       = '0;
        credit_return = 1'b0;
        hold_credits  = 1'b0;
        cycle         = 0;
        out_count     = 0;
        in_flight     = 0;
        model_bits    = '0;
        model_errs    = '0;
        for (int b = 0; b < W; b++) in_errs[b] = '0;
        for (int t = 0; t < `DET_TAPS; t++) begin
            tap_int[t] = 8 + $unsigned($random(seed)) % 17;
            if ($random(seed) % 2 != 0) tap_int[t] = -tap_int[t];
            taps[t] = tap_t'(tap_int[t]);
            tap_vec[t*TB +: TB] = taps[t];
        end
        repeat (8) @(posedge clk);
        #0.5;
        reset = 1'b0;
        @(negedge clk);
        check_value("out_valid", 0, out_valid);
        check_value("in_ready", 1, in_ready);

        run_burst(6, 1'b0);
        run_burst(1, 1'b1);   // Single word leaves through the flush path
        // The second burst must start from a cleared history
        first = out_count;
        send_burst(9, 1'b1);
        send_burst(5, 1'b1);
        wait_outputs(first + 14);
        check_value("output count", 14, out_count - first);

        // Withheld credits stall the burst once the granted ones are spent
        @(negedge clk);
        hold_credits = 1'b1;
        first = out_count;
        fork
            send_burst(8, 1'b1);
            begin
                wait_outputs(first + `DET_CREDITS);
                repeat (20) @(negedge clk);
                check_value("outputs with credits held", `DET_CREDITS, out_count - first);
                hold_credits = 1'b0;
            end
        join
        wait_outputs(first + 8);
        check_value("output count", 8, out_count - first);

        repeat (12) run_burst(1 + $unsigned($random(seed)) % 12, 1'b1);
        for (int c = 0; c < 4; c++) begin
            if (cand_hits[c] == 0) abort_run($sformatf("Hypothesis %0d never won", c));
        end
        $display("sim passed");
        $finish;
    end

endmodule : tb_sliding_detector

//--- vlog.f
+incdir+src
src/detector_pkg.sv
src/history_if.sv
src/word_history.sv
src/sliding_detector.sv
src/error_corrector.sv
src/credit_counter.sv
src/detector_ctrl.sv
src/sliding_detector_top.sv
verification/tb_sliding_detector.sv
